//--- filelist.f
hw/trace_pkg.sv
hw/stage_tag_tracker.sv
hw/trace_record_store.sv
hw/retire_fifo.sv
hw/trace_wb_slave.sv
hw/pipeline_trace_top.sv
tb/tb_clock_gen.sv
tb/trace_checker.sv
tb/tb_pipeline_trace.sv

//--- hw/pipeline_trace_top.sv
// Pipeline retirement trace unit, top level
// Tag tracker feeds the record store, retired records queue in a FIFO
// and a Wishbone classic slave lets the host read them out
`timescale 1ns/1ns
`default_nettype none

module pipeline_trace_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  trace_pkg::pc_t       fetch_pc,
    input  trace_pkg::opcode_t   decode_opcode,
    input  trace_pkg::wb_data_t  wb_data,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  trace_pkg::bus_addr_t wb_adr,
    input  trace_pkg::bus_data_t wb_dat_w,
    output trace_pkg::bus_data_t wb_dat_r,
    output logic                 wb_ack
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////////////////////
    logic                  fetch_valid, decode_valid, execute_valid;
    logic                  memory_valid, wb_valid;
    trace_pkg::tag_t       fetch_tag, decode_tag, wb_tag;

    logic                  rec_push;    // Store to FIFO
    trace_pkg::tag_t       rec_tag;
    trace_pkg::pc_t        rec_pc;
    trace_pkg::opcode_t    rec_opcode;
    trace_pkg::stall_cnt_t rec_stall_cnt;
    trace_pkg::wb_data_t   rec_wb_data;

    trace_pkg::tag_t       head_tag;    // FIFO to slave
    trace_pkg::pc_t        head_pc;
    trace_pkg::opcode_t    head_opcode;
    trace_pkg::stall_cnt_t head_stall_cnt;
    trace_pkg::wb_data_t   head_wb_data;
    trace_pkg::fifo_cnt_t  fifo_count;
    logic                  overflow;
    logic                  fifo_pop, overflow_clear;

    stage_tag_tracker u_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .fetch_valid   (fetch_valid),
        .decode_valid  (decode_valid),
        .execute_valid (execute_valid),
        .memory_valid  (memory_valid),
        .wb_valid      (wb_valid),
        .fetch_tag     (fetch_tag),
        .decode_tag    (decode_tag),
        .wb_tag        (wb_tag)
    );

    trace_record_store u_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .fetch_valid   (fetch_valid),
        .decode_valid  (decode_valid),
        .execute_valid (execute_valid),
        .memory_valid  (memory_valid),
        .wb_valid      (wb_valid),
        .fetch_tag     (fetch_tag),
        .decode_tag    (decode_tag),
        .wb_tag        (wb_tag),
        .fetch_pc      (fetch_pc),
        .decode_opcode (decode_opcode),
        .wb_data       (wb_data),
        .rec_push      (rec_push),
        .rec_tag       (rec_tag),
        .rec_pc        (rec_pc),
        .rec_opcode    (rec_opcode),
        .rec_stall_cnt (rec_stall_cnt),
        .rec_wb_data   (rec_wb_data)
    );

    retire_fifo u_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (rec_push),
        .pop            (fifo_pop),
        .overflow_clear (overflow_clear),
        .rec_tag        (rec_tag),
        .rec_pc         (rec_pc),
        .rec_opcode     (rec_opcode),
        .rec_stall_cnt  (rec_stall_cnt),
        .rec_wb_data    (rec_wb_data),
        .head_tag       (head_tag),
        .head_pc        (head_pc),
        .head_opcode    (head_opcode),
        .head_stall_cnt (head_stall_cnt),
        .head_wb_data   (head_wb_data),
        .fifo_count     (fifo_count),
        .overflow       (overflow)
    );

    trace_wb_slave u_wb_slave (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .head_tag       (head_tag),
        .head_pc        (head_pc),
        .head_opcode    (head_opcode),
        .head_stall_cnt (head_stall_cnt),
        .head_wb_data   (head_wb_data),
        .fifo_count     (fifo_count),
        .overflow       (overflow),
        .fifo_pop       (fifo_pop),
        .overflow_clear (overflow_clear)
    );

endmodule

`default_nettype wire

//--- hw/retire_fifo.sv
// Retired record queue
// Circular buffer of FIFO_DEPTH records. Pushes into a full queue are
// dropped and latch a sticky overflow flag until the host clears it
`timescale 1ns/1ns
`default_nettype none

module retire_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic                  pop,
    input  logic                  overflow_clear,
    input  trace_pkg::tag_t       rec_tag,
    input  trace_pkg::pc_t        rec_pc,
    input  trace_pkg::opcode_t    rec_opcode,
    input  trace_pkg::stall_cnt_t rec_stall_cnt,
    input  trace_pkg::wb_data_t   rec_wb_data,
    output trace_pkg::tag_t       head_tag,
    output trace_pkg::pc_t        head_pc,
    output trace_pkg::opcode_t    head_opcode,
    output trace_pkg::stall_cnt_t head_stall_cnt,
    output trace_pkg::wb_data_t   head_wb_data,
    output trace_pkg::fifo_cnt_t  fifo_count,
    output logic                  overflow
);

    trace_pkg::tag_t       tag_mem   [trace_pkg::FIFO_DEPTH];
    trace_pkg::pc_t        pc_mem    [trace_pkg::FIFO_DEPTH];
    trace_pkg::opcode_t    op_mem    [trace_pkg::FIFO_DEPTH];
    trace_pkg::stall_cnt_t stall_mem [trace_pkg::FIFO_DEPTH];
    trace_pkg::wb_data_t   data_mem  [trace_pkg::FIFO_DEPTH];

    trace_pkg::fifo_ptr_t wr_ptr;
    trace_pkg::fifo_ptr_t rd_ptr;
    logic full;
    logic do_push;
    logic do_pop;

    assign full    = (fifo_count == trace_pkg::fifo_cnt_t'(trace_pkg::FIFO_DEPTH));
    assign do_push = push && !full;             // Full queue drops the record
    assign do_pop  = pop && fifo_count != '0;   // Pop on empty is ignored

    always_ff @(posedge clk) begin
        if (do_push) begin
            tag_mem[wr_ptr]   <= rec_tag;
            pc_mem[wr_ptr]    <= rec_pc;
            op_mem[wr_ptr]    <= rec_opcode;
            stall_mem[wr_ptr] <= rec_stall_cnt;
            data_mem[wr_ptr]  <= rec_wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            overflow   <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            if (push && full) begin
                overflow <= 1'b1;       // A new loss wins over a clear
            end else if (overflow_clear) begin
                overflow <= 1'b0;
            end
        end
    end

    // Head record, meaningful only while fifo_count is nonzero
    assign head_tag       = tag_mem[rd_ptr];
    assign head_pc        = pc_mem[rd_ptr];
    assign head_opcode    = op_mem[rd_ptr];
    assign head_stall_cnt = stall_mem[rd_ptr];
    assign head_wb_data   = data_mem[rd_ptr];

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_count <= trace_pkg::fifo_cnt_t'(trace_pkg::FIFO_DEPTH));

endmodule

`default_nettype wire

//--- hw/stage_tag_tracker.sv
// Pipeline stage tag tracker
// Follows each instruction through fetch, decode, execute, memory and
// write-back. Stall holds fetch and decode and puts a bubble in execute.
`timescale 1ns/1ns
`default_nettype none

module stage_tag_tracker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    output logic            fetch_valid,
    output logic            decode_valid,
    output logic            execute_valid,
    output logic            memory_valid,
    output logic            wb_valid,
    output trace_pkg::tag_t fetch_tag,
    output trace_pkg::tag_t decode_tag,
    output trace_pkg::tag_t wb_tag
);

    trace_pkg::tag_t next_tag;      // Tag for the next fetch
    trace_pkg::tag_t execute_tag;
    trace_pkg::tag_t memory_tag;

    // Valid bits and tag counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_tag      <= '0;
            fetch_valid   <= 1'b0;
            decode_valid  <= 1'b0;
            execute_valid <= 1'b0;
            memory_valid  <= 1'b0;
            wb_valid      <= 1'b0;
        end else begin
            if (!stall) begin
                fetch_valid   <= 1'b1;          // New instruction every free cycle
                next_tag      <= next_tag + 1'b1;
                decode_valid  <= fetch_valid;
                execute_valid <= decode_valid;
            end else begin
                execute_valid <= 1'b0;          // Bubble, fetch and decode hold
            end
            memory_valid <= execute_valid;      // Back end never stalls
            wb_valid     <= memory_valid;
        end
    end

    // Tags follow the same rule, qualified by the valids above
    always_ff @(posedge clk) begin
        if (!stall) begin
            fetch_tag   <= next_tag;
            decode_tag  <= fetch_tag;
            execute_tag <= decode_tag;
        end
        memory_tag <= execute_tag;
        wb_tag     <= memory_tag;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    logic [4:0]      stage_vld;
    trace_pkg::tag_t stage_tag [5];
    logic            tag_clash;

    assign stage_vld = {wb_valid, memory_valid, execute_valid, decode_valid, fetch_valid};
    assign stage_tag = '{fetch_tag, decode_tag, execute_tag, memory_tag, wb_tag};

    always_comb begin
        tag_clash = 1'b0;
        for (int i = 0; i < 5; i++) begin
            for (int j = i + 1; j < 5; j++) begin
                if (stage_vld[i] && stage_vld[j] && stage_tag[i] == stage_tag[j]) begin
                    tag_clash = 1'b1;
                end
            end
        end
    end

    // Two live stages never carry the same instruction
    a_unique_tags: assert property (@(posedge clk) disable iff (!rst_n) !tag_clash);

endmodule

`default_nettype wire

//--- hw/trace_pkg.sv
// Retirement trace unit shared definitions
// Field widths, slot and queue depths, bus register map and
// the vector types used across tracker, store, FIFO and bus slave
`default_nettype none

package trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Depths
    ////////////////////////////////////////////////////////////////////////////
    localparam int SLOT_COUNT = 8;      // Record slots, more than 5 in flight
    localparam int FIFO_DEPTH = 4;      // Retired records queued for the host

    ////////////////////////////////////////////////////////////////////////////
    // Field types
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [7:0]  tag_t;         // Sequence tag, wraps after 255
    typedef logic [$clog2(SLOT_COUNT)-1:0] slot_t;  // Low tag bits
    typedef logic [15:0] pc_t;          // Fetch address
    typedef logic [7:0]  opcode_t;      // Decoded opcode
    typedef logic [15:0] wb_data_t;     // Write-back value
    typedef logic [3:0]  stall_cnt_t;   // Stall cycles in decode, saturating

    // Queue bookkeeping
    typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;  // 0..FIFO_DEPTH

    localparam stall_cnt_t STALL_CNT_MAX = 4'd15;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone register map
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [31:0] bus_data_t;
    typedef logic [1:0]  bus_addr_t;    // Word address

    localparam bus_addr_t ADDR_STATUS = 2'd0;  // Count and overflow
    localparam bus_addr_t ADDR_REC_LO = 2'd1;  // Opcode and pc, no pop
    localparam bus_addr_t ADDR_REC_HI = 2'd2;  // Tag, stalls, wb data, pops
    localparam int STATUS_OVF_BIT = 8;         // Overflow flag in STATUS

endpackage

`default_nettype wire

//--- hw/trace_record_store.sv
// Trace record store
// Collects pc, opcode and stall count per instruction in a slot memory
// indexed by the low tag bits, then emits the whole record in write-back
`timescale 1ns/1ns
`default_nettype none

module trace_record_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  fetch_valid,
    input  logic                  decode_valid,
    input  logic                  execute_valid,
    input  logic                  memory_valid,
    input  logic                  wb_valid,
    input  trace_pkg::tag_t       fetch_tag,
    input  trace_pkg::tag_t       decode_tag,
    input  trace_pkg::tag_t       wb_tag,
    input  trace_pkg::pc_t        fetch_pc,
    input  trace_pkg::opcode_t    decode_opcode,
    input  trace_pkg::wb_data_t   wb_data,
    output logic                  rec_push,
    output trace_pkg::tag_t       rec_tag,
    output trace_pkg::pc_t        rec_pc,
    output trace_pkg::opcode_t    rec_opcode,
    output trace_pkg::stall_cnt_t rec_stall_cnt,
    output trace_pkg::wb_data_t   rec_wb_data
);

    // Slot memories, one entry per tag modulo SLOT_COUNT
    trace_pkg::pc_t        pc_mem    [trace_pkg::SLOT_COUNT];
    trace_pkg::opcode_t    op_mem    [trace_pkg::SLOT_COUNT];
    trace_pkg::stall_cnt_t stall_mem [trace_pkg::SLOT_COUNT];

    trace_pkg::stall_cnt_t dec_stall_cnt;   // Stalls of the tag now in decode
    trace_pkg::slot_t      fetch_slot;
    trace_pkg::slot_t      decode_slot;
    trace_pkg::slot_t      wb_slot;

    assign fetch_slot  = fetch_tag[$bits(trace_pkg::slot_t)-1:0];
    assign decode_slot = decode_tag[$bits(trace_pkg::slot_t)-1:0];
    assign wb_slot     = wb_tag[$bits(trace_pkg::slot_t)-1:0];

    // Decode stall counter, restarts whenever decode takes a new tag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_stall_cnt <= '0;
        end else if (!stall) begin
            dec_stall_cnt <= '0;
        end else if (decode_valid && dec_stall_cnt != trace_pkg::STALL_CNT_MAX) begin
            dec_stall_cnt <= dec_stall_cnt + 1'b1;  // Saturates at 15
        end
    end

    // Field capture, the last write while a stage holds a tag wins
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pc_mem[fetch_slot] <= fetch_pc;
        end
        if (decode_valid) begin
            op_mem[decode_slot] <= decode_opcode;
        end
        if (decode_valid && !stall) begin
            stall_mem[decode_slot] <= dec_stall_cnt;  // Committed as tag leaves decode
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Record out, live wb_data joins the stored fields
    ////////////////////////////////////////////////////////////////////////////
    assign rec_push      = wb_valid;
    assign rec_tag       = wb_tag;
    assign rec_pc        = pc_mem[wb_slot];
    assign rec_opcode    = op_mem[wb_slot];
    assign rec_stall_cnt = stall_mem[wb_slot];
    assign rec_wb_data   = wb_data;

    // Youngest fetch stays within SLOT_COUNT of the retiring tag, so its slot is intact
    a_slot_free: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid && fetch_valid) |->
            trace_pkg::tag_t'(fetch_tag - wb_tag) <
            trace_pkg::tag_t'(trace_pkg::SLOT_COUNT));

endmodule

`default_nettype wire

//--- hw/trace_wb_slave.sv
// Wishbone classic register slave for the trace queue
// STATUS gives count and overflow, REC_LO and REC_HI give the head record.
// A REC_HI read pops it, a STATUS write with bit 8 clears overflow
`timescale 1ns/1ns
`default_nettype none

module trace_wb_slave (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  trace_pkg::bus_addr_t  wb_adr,
    input  trace_pkg::bus_data_t  wb_dat_w,
    output trace_pkg::bus_data_t  wb_dat_r,
    output logic                  wb_ack,
    input  trace_pkg::tag_t       head_tag,
    input  trace_pkg::pc_t        head_pc,
    input  trace_pkg::opcode_t    head_opcode,
    input  trace_pkg::stall_cnt_t head_stall_cnt,
    input  trace_pkg::wb_data_t   head_wb_data,
    input  trace_pkg::fifo_cnt_t  fifo_count,
    input  logic                  overflow,
    output logic                  fifo_pop,
    output logic                  overflow_clear
);

    typedef enum logic [1:0] {S_IDLE, S_ACK, S_REST} wb_state_t;

    wb_state_t            state;
    logic                 req;          // Transfer accepted this cycle
    logic                 has_rec;
    trace_pkg::bus_data_t rd_word;

    assign req     = wb_cyc && wb_stb && state == S_IDLE;
    assign has_rec = (fifo_count != '0);

    // Read word for the addressed register
    always_comb begin
        rd_word = '0;
        case (wb_adr)
            trace_pkg::ADDR_STATUS: begin
                rd_word[$bits(trace_pkg::fifo_cnt_t)-1:0] = fifo_count;
                rd_word[trace_pkg::STATUS_OVF_BIT]        = overflow;
            end
            trace_pkg::ADDR_REC_LO: if (has_rec) rd_word = {8'h00, head_opcode, head_pc};
            trace_pkg::ADDR_REC_HI: if (has_rec) begin
                rd_word = {head_tag, 4'h0, head_stall_cnt, head_wb_data};
            end
            default: rd_word = '0;      // Unmapped word reads zero
        endcase
    end

    // Handshake FSM, one ack cycle then one rest cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            fifo_pop       <= 1'b0;
            overflow_clear <= 1'b0;
        end else begin
            fifo_pop       <= 1'b0;
            overflow_clear <= 1'b0;
            case (state)
                S_IDLE: if (req) begin
                    state    <= S_ACK;
                    // Pop only what was captured, a late push must survive
                    fifo_pop <= !wb_we && wb_adr == trace_pkg::ADDR_REC_HI && has_rec;
                    overflow_clear <= wb_we && wb_adr == trace_pkg::ADDR_STATUS &&
                                      wb_dat_w[trace_pkg::STATUS_OVF_BIT];
                end
                S_ACK:   state <= S_REST;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req) wb_dat_r <= wb_we ? '0 : rd_word;  // Sampled before any pop
    end

    assign wb_ack = (state == S_ACK);

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the trace unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_pipeline_trace \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

//--- tb/tb_clock_gen.sv
// Testbench clock and reset source
// 40 ns clock, synchronous active-low reset held for 5 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;
    always #20 clk = ~clk;              // 40 ns period

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;                // Released clear of the edge
    end

endmodule

`default_nettype wire

//--- tb/tb_pipeline_trace.sv
// Testbench for the pipeline retirement trace unit
// Drives stall patterns and random stage values from a table, keeps a
// reference model of tags, stall counts and the retire queue, and reads
// the queue back over Wishbone
`timescale 1ns/1ns
`default_nettype none

module tb_pipeline_trace;

    localparam int ROWS = 7;

    logic        clk, rst_n;
    logic        stall;
    logic [15:0] fetch_pc;
    logic [7:0]  decode_opcode;
    logic [15:0] wb_data;
    logic        wb_cyc, wb_stb, wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic        wb_ack;
    logic [31:0] exp_data;              // Expected word for the checker
    int          err_count, check_count;

    // Stimulus table: stall pattern, run cycles, drain, clear overflow
    logic [15:0] pat_tab   [ROWS];
    int          run_tab   [ROWS];
    bit          drain_tab [ROWS];
    bit          clear_tab [ROWS];

    logic [31:0] rng;
    int          cycle_cnt = 0;
    int          cycle_limit = 200;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    pipeline_trace_top uut (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .fetch_pc(fetch_pc), .decode_opcode(decode_opcode), .wb_data(wb_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    trace_checker u_chk (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_ack(wb_ack), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_r(wb_dat_r), .exp_data(exp_data),
        .err_count(err_count), .check_count(check_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of the stage rules and the retire queue
    ////////////////////////////////////////////////////////////////////////////
    logic        m_fv, m_dv, m_ev, m_mv, m_wv;
    logic [7:0]  m_ft, m_dt, m_et, m_mt, m_wt, m_next;
    logic        m_ovf;
    logic [15:0] pc_a  [256];           // Indexed by full tag, no slot reuse
    logic [7:0]  op_a  [256];
    logic [3:0]  cnt_a [256];
    logic [51:0] exp_q [$];             // {tag, pc, opcode, stalls, wb data}

    always @(posedge clk) begin
        if (!rst_n) begin
            {m_fv, m_dv, m_ev, m_mv, m_wv} = 5'b0;
            {m_ft, m_dt, m_et, m_mt, m_wt} = 40'b0;
            m_next = 8'd0;
            m_ovf  = 1'b0;
            exp_q.delete();
        end else begin
            if (m_fv) pc_a[m_ft] = fetch_pc;          // Last write wins
            if (m_dv) op_a[m_dt] = decode_opcode;
            if (m_dv && stall && cnt_a[m_dt] != 4'd15) cnt_a[m_dt] = cnt_a[m_dt] + 4'd1;
            if (m_wv) begin
                if (exp_q.size() < 4) begin
                    exp_q.push_back({m_wt, pc_a[m_wt], op_a[m_wt], cnt_a[m_wt], wb_data});
                end else begin
                    m_ovf = 1'b1;                     // Record lost
                end
            end
            // Host side effects, seen in the ack cycle
            if (wb_ack && !wb_we && wb_adr == 2'd2 && exp_q.size() > 0) exp_q.pop_front();
            if (wb_ack && wb_we && wb_adr == 2'd0 && wb_dat_w[8]) m_ovf = 1'b0;
            // Back end always advances
            m_wv = m_mv;
            m_wt = m_mt;
            m_mv = m_ev;
            m_mt = m_et;
            if (!stall) begin
                m_ev = m_dv;
                m_et = m_dt;
                m_dv = m_fv;
                m_dt = m_ft;
                if (m_fv) cnt_a[m_ft] = 4'd0;         // Fresh entry into decode
                m_fv   = 1'b1;
                m_ft   = m_next;
                m_next = m_next + 8'd1;
            end else begin
                m_ev = 1'b0;                          // Bubble into execute
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // One pipeline cycle, inputs move 2 ns after the edge
    task automatic drive_cycle(input logic s);
        stall = s;
        rng = xorshift32(rng);
        fetch_pc = rng[15:0];
        rng = xorshift32(rng);
        decode_opcode = rng[7:0];
        rng = xorshift32(rng);
        wb_data = rng[15:0];
        @(posedge clk);
        #2;
    endtask

    // Single Wishbone transfer, cyc and stb held until ack is sampled
    task automatic bus_xfer(input logic we, input logic [1:0] adr,
                            input logic [31:0] wdat, input logic [31:0] expect_val);
        exp_data = expect_val;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (!wb_ack);            // Watchdog bounds this wait
        @(negedge clk);                 // Checker compares here
        @(posedge clk);                 // Ack taken on this edge
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    function automatic logic [31:0] status_word();
        return {23'd0, m_ovf, 5'd0, 3'(exp_q.size())};
    endfunction

    task automatic drain_queue();
        int          n;
        logic [51:0] r;
        n = exp_q.size();
        for (int i = 0; i < n; i++) begin
            r = exp_q[0];
            bus_xfer(1'b0, 2'd1, 32'd0, {8'h00, r[27:20], r[43:28]});
            bus_xfer(1'b0, 2'd2, 32'd0, {r[51:44], 4'h0, r[19:16], r[15:0]});
        end
        bus_xfer(1'b0, 2'd0, 32'd0, status_word());   // Empty now
    endtask

    // Watchdog sized from the table
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycle_cnt);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        stall = 1'b1;                   // Pipeline idle until a row runs
        fetch_pc = '0;
        decode_opcode = '0;
        wb_data = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        exp_data = '0;
        rng = 32'hf772;

        // Row 1 holds one tag in decode for 3 stalls and retires exactly 4 records
        pat_tab   = '{16'h0000, 16'h000e, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0f0f};
        run_tab   = '{5, 7, 12, 0, 0, 270, 10};
        drain_tab = '{1, 1, 0, 0, 1, 1, 1};     // Row 2 overflows, row 3 only clears
        clear_tab = '{0, 0, 0, 1, 0, 1, 0};
        for (int i = 0; i < ROWS; i++) cycle_limit = cycle_limit + run_tab[i] + 80;

        @(posedge rst_n);
        @(posedge clk);
        #2;

        // Reset state, record reads are empty and pop nothing
        bus_xfer(1'b0, 2'd0, 32'd0, 32'd0);
        bus_xfer(1'b0, 2'd1, 32'd0, 32'd0);
        bus_xfer(1'b0, 2'd2, 32'd0, 32'd0);
        bus_xfer(1'b0, 2'd0, 32'd0, 32'd0);
        $display("test 0 done: reset reads, errors so far %0d", err_count);

        for (int t = 0; t < ROWS; t++) begin
            for (int c = 0; c < run_tab[t]; c++) drive_cycle(pat_tab[t][c % 16]);
            repeat (4) drive_cycle(1'b1);           // Flush the back end
            bus_xfer(1'b0, 2'd0, 32'd0, status_word());
            if (drain_tab[t]) drain_queue();
            if (clear_tab[t]) begin
                bus_xfer(1'b1, 2'd0, 32'h0000_0100, 32'd0);
                bus_xfer(1'b0, 2'd0, 32'd0, status_word());
            end
            $display("test %0d done: pattern %h, %0d cycles, next tag %h, errors so far %0d",
                     t + 1, pat_tab[t], run_tab[t], m_next, err_count);
        end

        $display("%0d reads checked, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/trace_checker.sv
// Bus read checker
// Watches every acknowledged Wishbone read and compares the returned
// word with the expected value set up by the testbench top
`timescale 1ns/1ns
`default_nettype none

module trace_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_ack,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_r,
    input  logic [31:0] exp_data,
    output int          err_count,
    output int          check_count
);

    int errs   = 0;
    int checks = 0;

    assign err_count   = errs;
    assign check_count = checks;

    function automatic string reg_name(input logic [1:0] adr);
        case (adr)
            2'd0:    return "STATUS";
            2'd1:    return "REC_LO";
            2'd2:    return "REC_HI";
            default: return "UNMAPPED";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare on the falling edge, ack and read data are settled there
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n && wb_ack) begin
            // Ack outside a live cycle means the slave ran on its own
            if (!(wb_cyc && wb_stb)) begin
                errs = errs + 1;
                $display("Ack seen without an active bus cycle");
            end
            if (!wb_we) begin
                checks = checks + 1;
                if (wb_dat_r !== exp_data) begin
                    errs = errs + 1;
                    $display("ERROR wb_dat_r (%s): expected %h, got %h",
                             reg_name(wb_adr), exp_data, wb_dat_r);
                end
            end
        end
    end

endmodule

`default_nettype wire
